// ==== source/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int MEM_ADDR_W = 14;  // 16 K words

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
    localparam logic [XLEN-1:0] OUT_ADDR = 32'h0002_0020;  // byte output port

    localparam string MEM_INIT_FILE = "program.hex";

    // major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    // alu funct3
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // load/store size funct3
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    localparam logic [6:0] F7_ALT = 7'b0100000;  // sub / sra

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASSB
    } alu_op_e;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } rv_inst_u;

endpackage

// ==== source/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode (
    input  logic [rv_pkg::XLEN-1:0]       i_inst,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_rs1,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_rs2,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_rd,
    output logic [rv_pkg::XLEN-1:0]       o_imm,
    output rv_pkg::alu_op_e               o_alu_op,
    output logic [2:0]                    o_funct3,
    output logic                          o_use_imm,
    output logic                          o_use_pc,
    output logic                          o_is_branch,
    output logic                          o_is_jal,
    output logic                          o_is_jalr,
    output logic                          o_is_load,
    output logic                          o_is_store,
    output logic                          o_reg_write
);
    import rv_pkg::*;

    rv_inst_u inst;
    logic     f7_zero;
    logic     f7_alt;

    assign inst    = i_inst;
    assign f7_zero = (inst.r.funct7 == 7'b0000000);
    assign f7_alt  = (inst.r.funct7 == F7_ALT);

    assign o_rs1    = inst.r.rs1;
    assign o_rs2    = inst.r.rs2;
    assign o_rd     = inst.r.rd;
    assign o_funct3 = inst.r.funct3;

    function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        o_imm       = '0;
        o_alu_op    = ALU_ADD;
        o_use_imm   = 1'b0;
        o_use_pc    = 1'b0;
        o_is_branch = 1'b0;
        o_is_jal    = 1'b0;
        o_is_jalr   = 1'b0;
        o_is_load   = 1'b0;
        o_is_store  = 1'b0;
        o_reg_write = 1'b0;

        case (inst.r.opcode)
            OP_LUI: begin
                o_imm       = {inst.u.imm, 12'b0};
                o_alu_op    = ALU_PASSB;
                o_use_imm   = 1'b1;
                o_reg_write = 1'b1;
            end
            OP_AUIPC: begin
                o_imm       = {inst.u.imm, 12'b0};
                o_use_imm   = 1'b1;
                o_use_pc    = 1'b1;
                o_reg_write = 1'b1;
            end
            OP_JAL: begin
                o_imm       = {{12{inst.j.imm_20}}, inst.j.imm_19_12, inst.j.imm_11,
                               inst.j.imm_10_1, 1'b0};
                o_use_imm   = 1'b1;
                o_use_pc    = 1'b1;  // alu forms the target
                o_is_jal    = 1'b1;
                o_reg_write = 1'b1;
            end
            OP_JALR: begin
                o_imm       = {{20{inst.i.imm[11]}}, inst.i.imm};
                o_use_imm   = 1'b1;
                o_is_jalr   = (inst.i.funct3 == 3'b000);
                o_reg_write = (inst.i.funct3 == 3'b000);
            end
            OP_BRANCH: begin
                o_imm       = {{20{inst.b.imm_12}}, inst.b.imm_11, inst.b.imm_10_5,
                               inst.b.imm_4_1, 1'b0};
                o_use_imm   = 1'b1;
                o_use_pc    = 1'b1;
                o_is_branch = (inst.b.funct3 != 3'b010) && (inst.b.funct3 != 3'b011);
            end
            OP_LOAD: begin
                o_imm       = {{20{inst.i.imm[11]}}, inst.i.imm};
                o_use_imm   = 1'b1;
                o_is_load   = (inst.i.funct3 inside {F3_B, F3_H, F3_W, F3_BU, F3_HU});
                o_reg_write = o_is_load;
            end
            OP_STORE: begin
                o_imm      = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
                o_use_imm  = 1'b1;
                o_is_store = (inst.s.funct3 inside {F3_B, F3_H, F3_W});
            end
            OP_IMM: begin
                o_imm     = {{20{inst.i.imm[11]}}, inst.i.imm};
                o_use_imm = 1'b1;
                o_alu_op  = alu_from_f3(inst.i.funct3, (inst.i.funct3 == F3_SR) && f7_alt);
                case (inst.i.funct3)
                    F3_SLL:  o_reg_write = f7_zero;
                    F3_SR:   o_reg_write = f7_zero || f7_alt;
                    default: o_reg_write = 1'b1;
                endcase
            end
            OP_REG: begin
                o_alu_op    = alu_from_f3(inst.r.funct3, f7_alt);
                o_reg_write = f7_zero ||
                              (f7_alt && (inst.r.funct3 inside {F3_ADD, F3_SR}));
            end
            default: ;  // unsupported, behaves as nop
        endcase
    end

endmodule

// ==== source/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
    input  logic                          clk,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs2,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rd,
    input  logic                          i_we,
    input  logic [rv_pkg::XLEN-1:0]       i_wdata,
    output logic [rv_pkg::XLEN-1:0]       o_rdata1,
    output logic [rv_pkg::XLEN-1:0]       o_rdata2
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [1:31];  // x0 has no storage

    assign o_rdata1 = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rdata2 = (i_rs2 == '0) ? '0 : regs[i_rs2];

    always_ff @(posedge clk) begin
        if (i_we && (i_rd != '0)) begin
            regs[i_rd] <= i_wdata;
        end
    end

endmodule

// ==== source/rv_exec.sv ====
`timescale 1ns/1ps

module rv_exec (
    input  logic [rv_pkg::XLEN-1:0] i_pc,
    input  logic [rv_pkg::XLEN-1:0] i_rdata1,
    input  logic [rv_pkg::XLEN-1:0] i_rdata2,
    input  logic [rv_pkg::XLEN-1:0] i_imm,
    input  rv_pkg::alu_op_e         i_alu_op,
    input  logic [2:0]              i_funct3,
    input  logic                    i_use_imm,
    input  logic                    i_use_pc,
    input  logic                    i_is_branch,
    input  logic                    i_is_jal,
    input  logic                    i_is_jalr,
    input  logic                    i_is_store,
    output logic [rv_pkg::XLEN-1:0] o_result,
    output logic                    o_jump,
    output logic [rv_pkg::XLEN-1:0] o_target,
    output logic [rv_pkg::XLEN-1:0] o_addr,
    output logic                    o_out_hit
);
    import rv_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_out;
    logic [4:0]      shamt;
    logic            take;
    logic            eq;
    logic            lt;
    logic            ltu;

    assign op_a  = i_use_pc ? i_pc : i_rdata1;
    assign op_b  = i_use_imm ? i_imm : i_rdata2;
    assign shamt = op_b[4:0];

    always_comb begin
        case (i_alu_op)
            ALU_ADD:   alu_out = op_a + op_b;
            ALU_SUB:   alu_out = op_a - op_b;
            ALU_AND:   alu_out = op_a & op_b;
            ALU_OR:    alu_out = op_a | op_b;
            ALU_XOR:   alu_out = op_a ^ op_b;
            ALU_SLL:   alu_out = op_a << shamt;
            ALU_SRL:   alu_out = op_a >> shamt;
            ALU_SRA:   alu_out = $unsigned($signed(op_a) >>> shamt);
            ALU_SLT:   alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:  alu_out = {31'b0, op_a < op_b};
            ALU_PASSB: alu_out = op_b;
            default:   alu_out = '0;
        endcase
    end

    // branch compare always on the two registers
    assign eq  = (i_rdata1 == i_rdata2);
    assign lt  = ($signed(i_rdata1) < $signed(i_rdata2));
    assign ltu = (i_rdata1 < i_rdata2);

    always_comb begin
        case (i_funct3)
            F3_BEQ:  take = eq;
            F3_BNE:  take = !eq;
            F3_BLT:  take = lt;
            F3_BGE:  take = !lt;
            F3_BLTU: take = ltu;
            F3_BGEU: take = !ltu;
            default: take = 1'b0;
        endcase
    end

    assign o_result = (i_is_jal || i_is_jalr) ? i_pc + 32'd4 : alu_out;  // link value
    assign o_jump   = i_is_jal || i_is_jalr || (i_is_branch && take);
    assign o_target = {alu_out[XLEN-1:1], 1'b0};  // jalr drops bit 0
    assign o_addr   = alu_out;

    assign o_out_hit = i_is_store && (i_funct3 == F3_B) && (alu_out == OUT_ADDR);

endmodule

// ==== source/rv_mem.sv ====
`timescale 1ns/1ps

module rv_mem (
    input  logic                          clk,
    input  logic [rv_pkg::MEM_ADDR_W-1:0] i_fetch_addr,
    input  logic [rv_pkg::XLEN-1:0]       i_addr,
    input  logic [2:0]                    i_funct3,
    input  logic                          i_load,
    input  logic                          i_store,
    input  logic [rv_pkg::XLEN-1:0]       i_wdata,
    output logic [rv_pkg::XLEN-1:0]       o_inst,
    output logic [rv_pkg::XLEN-1:0]       o_load_data
);
    import rv_pkg::*;

    logic [XLEN-1:0] mem [2**MEM_ADDR_W];

    logic [MEM_ADDR_W-1:0] word_addr;
    logic [XLEN-1:0]       word;
    logic [7:0]            byte_lane;
    logic [15:0]           half_lane;
    logic [XLEN-1:0]       ext;
    logic [3:0]            be;
    logic [XLEN-1:0]       lane_data;

    initial begin
        $readmemh(MEM_INIT_FILE, mem);
    end

    assign o_inst    = mem[i_fetch_addr];
    assign word_addr = i_addr[MEM_ADDR_W+1:2];
    assign word      = mem[word_addr];

    assign byte_lane = word[8*i_addr[1:0] +: 8];
    assign half_lane = i_addr[1] ? word[31:16] : word[15:0];

    always_comb begin
        case (i_funct3)
            F3_B:    ext = {{24{byte_lane[7]}}, byte_lane};
            F3_BU:   ext = {24'b0, byte_lane};
            F3_H:    ext = {{16{half_lane[15]}}, half_lane};
            F3_HU:   ext = {16'b0, half_lane};
            F3_W:    ext = word;
            default: ext = '0;
        endcase
    end

    assign o_load_data = i_load ? ext : '0;

    // byte enables and lane-replicated store data
    always_comb begin
        case (i_funct3)
            F3_B: begin
                be        = 4'b0001 << i_addr[1:0];
                lane_data = {4{i_wdata[7:0]}};
            end
            F3_H: begin
                be        = i_addr[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{i_wdata[15:0]}};
            end
            default: begin
                be        = 4'b1111;
                lane_data = i_wdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_store) begin
            for (int k = 0; k < 4; k++) begin
                if (be[k]) begin
                    mem[word_addr][8*k +: 8] <= lane_data[8*k +: 8];  // other lanes kept
                end
            end
        end
    end

endmodule

// ==== source/rv_core.sv ====
`timescale 1ns/1ps

module rv_core (
    input  logic       clk,
    input  logic       reset,
    input  logic       i_wb_ack,
    output logic       o_wb_cyc,
    output logic       o_wb_stb,
    output logic       o_wb_we,
    output logic [7:0] o_wb_dat
);
    import rv_pkg::*;

    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       next_pc;
    logic [XLEN-1:0]       inst;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm;
    alu_op_e               alu_op;
    logic [2:0]            funct3;
    logic                  use_imm;
    logic                  use_pc;
    logic                  is_branch;
    logic                  is_jal;
    logic                  is_jalr;
    logic                  is_load;
    logic                  is_store;
    logic                  reg_write;
    logic [XLEN-1:0]       rdata1;
    logic [XLEN-1:0]       rdata2;
    logic [XLEN-1:0]       result;
    logic                  jump;
    logic [XLEN-1:0]       target;
    logic [XLEN-1:0]       addr;
    logic                  out_hit;
    logic [XLEN-1:0]       load_data;
    logic [XLEN-1:0]       wb_value;
    logic                  stall;
    logic                  wb_req;
    logic [7:0]            wb_dat;

    // output store waits until its ack is seen
    assign stall = out_hit && !(wb_req && i_wb_ack);

    assign next_pc  = stall ? pc : (jump ? target : pc + 32'd4);
    assign wb_value = is_load ? load_data : result;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_req <= 1'b0;
        end else if (wb_req && i_wb_ack) begin
            wb_req <= 1'b0;
        end else if (out_hit && !wb_req) begin
            wb_req <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_hit && !wb_req) begin
            wb_dat <= rdata2[7:0];  // held stable for the whole request
        end
    end

    assign o_wb_cyc = wb_req;
    assign o_wb_stb = wb_req;
    assign o_wb_we  = wb_req;
    assign o_wb_dat = wb_dat;

    rv_decode u_decode (
        .i_inst      (inst),
        .o_rs1       (rs1),
        .o_rs2       (rs2),
        .o_rd        (rd),
        .o_imm       (imm),
        .o_alu_op    (alu_op),
        .o_funct3    (funct3),
        .o_use_imm   (use_imm),
        .o_use_pc    (use_pc),
        .o_is_branch (is_branch),
        .o_is_jal    (is_jal),
        .o_is_jalr   (is_jalr),
        .o_is_load   (is_load),
        .o_is_store  (is_store),
        .o_reg_write (reg_write)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .i_rs1    (rs1),
        .i_rs2    (rs2),
        .i_rd     (rd),
        .i_we     (reg_write && !stall),
        .i_wdata  (wb_value),
        .o_rdata1 (rdata1),
        .o_rdata2 (rdata2)
    );

    rv_exec u_exec (
        .i_pc        (pc),
        .i_rdata1    (rdata1),
        .i_rdata2    (rdata2),
        .i_imm       (imm),
        .i_alu_op    (alu_op),
        .i_funct3    (funct3),
        .i_use_imm   (use_imm),
        .i_use_pc    (use_pc),
        .i_is_branch (is_branch),
        .i_is_jal    (is_jal),
        .i_is_jalr   (is_jalr),
        .i_is_store  (is_store),
        .o_result    (result),
        .o_jump      (jump),
        .o_target    (target),
        .o_addr      (addr),
        .o_out_hit   (out_hit)
    );

    rv_mem u_mem (
        .clk          (clk),
        .i_fetch_addr (pc[MEM_ADDR_W+1:2]),
        .i_addr       (addr),
        .i_funct3     (funct3),
        .i_load       (is_load),
        .i_store      (is_store && !out_hit && !stall),  // port writes skip the ram
        .i_wdata      (rdata2),
        .o_inst       (inst),
        .o_load_data  (load_data)
    );

endmodule

// ==== bench/rv_core_asserts.sv ====
`timescale 1ns/1ps

module rv_core_asserts (
    input logic       clk,
    input logic       reset,
    input logic       i_wb_ack,
    input logic       o_wb_cyc,
    input logic       o_wb_stb,
    input logic       o_wb_we,
    input logic [7:0] o_wb_dat
);

    int   fail_count = 0;
    logic done_sent;

    always_ff @(posedge clk) begin
        if (reset) begin
            done_sent <= 1'b0;
        end else if (o_wb_stb && i_wb_ack && (o_wb_dat == 8'h44)) begin
            done_sent <= 1'b1;  // 'D' acknowledged
        end
    end

    stb_needs_cyc: assert property (@(posedge clk) disable iff (reset)
        o_wb_stb |-> o_wb_cyc)
    else begin
        $error("wishbone stb high without cyc");
        fail_count++;
    end

    // request held until the slave acks
    hold_until_ack: assert property (@(posedge clk) disable iff (reset)
        (o_wb_stb && !i_wb_ack) |=> (o_wb_stb && o_wb_we && $stable(o_wb_dat)))
    else begin
        $error("wishbone request dropped or changed before ack");
        fail_count++;
    end

    idle_after_reset: assert property (@(posedge clk)
        reset |=> (!o_wb_cyc && !o_wb_stb))
    else begin
        $error("wishbone cyc or stb high during or right after reset");
        fail_count++;
    end

    quiet_after_done: assert property (@(posedge clk) disable iff (reset)
        done_sent |-> !o_wb_stb)
    else begin
        $error("wishbone stb seen after the core halted");
        fail_count++;
    end

endmodule

// ==== bench/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_BYTES    = 6;
    localparam int HALT_CYCLES  = 50;
    // about 150 instructions plus 6 bytes of up to 9 cycles each with 10x margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic       clk;
    logic       reset;
    logic       i_wb_ack;
    logic       o_wb_cyc;
    logic       o_wb_stb;
    logic       o_wb_we;
    logic [7:0] o_wb_dat;

    string      expected_seq = "12345D";
    logic [7:0] lfsr;
    int         cycles = 0;
    int         bytes_seen = 0;
    int         err_count = 0;
    int         test_pass = 0;
    int         test_fail = 0;
    bit         timed_out = 1'b0;

    rv_core u_dut (
        .clk      (clk),
        .reset    (reset),
        .i_wb_ack (i_wb_ack),
        .o_wb_cyc (o_wb_cyc),
        .o_wb_stb (o_wb_stb),
        .o_wb_we  (o_wb_we),
        .o_wb_dat (o_wb_dat)
    );

    bind rv_core rv_core_asserts u_asserts (
        .clk      (clk),
        .reset    (reset),
        .i_wb_ack (i_wb_ack),
        .o_wb_cyc (o_wb_cyc),
        .o_wb_stb (o_wb_stb),
        .o_wb_we  (o_wb_we),
        .o_wb_dat (o_wb_dat)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic pick_ack_delay(output int n);
        n = 0;
        for (int k = 0; k < 3; k++) begin
            lfsr = lfsr_step(lfsr);
            n = (n << 1) | lfsr[0];
        end
    endtask

    task automatic check_byte(input logic [7:0] got);
        logic [7:0] want;
        if (bytes_seen >= NUM_BYTES) begin
            $display("unexpected extra byte 0x%02h after the done marker at %0t", got, $time);
            err_count++;
        end else begin
            want = expected_seq[bytes_seen];
            assert (got == want) else begin
                $display("ERR %0t o_wb_dat got 0x%02h expected 0x%02h", $time, got, want);
                err_count++;
            end
            if (bytes_seen < NUM_BYTES - 1) begin
                if (got == want) test_pass++;
                else test_fail++;
                $display("test %0d %s, received '%c'", bytes_seen + 1,
                         (got == want) ? "passed" : "failed", got);
            end else begin
                $display("done marker received '%c'", got);
            end
        end
        bytes_seen++;
    endtask

    // wishbone slave acks for one cycle after a random wait
    initial begin : wb_slave
        int wait_cycles;
        i_wb_ack = 1'b0;
        lfsr = 8'd80;
        forever begin
            @(posedge clk);
            #1;
            if (!reset && o_wb_stb) begin
                pick_ack_delay(wait_cycles);
                repeat (wait_cycles) begin
                    @(posedge clk);
                    #1;
                end
                i_wb_ack = 1'b1;
                check_byte(o_wb_dat);
                @(posedge clk);
                #1;
                i_wb_ack = 1'b0;
            end
        end
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        while ((bytes_seen < NUM_BYTES) && (cycles < TIMEOUT_CYCLES)) begin
            @(posedge clk);
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout, only %0d of %0d bytes arrived within %0d cycles",
                     bytes_seen, NUM_BYTES, TIMEOUT_CYCLES);
            timed_out = 1'b1;
        end else begin
            repeat (HALT_CYCLES) @(posedge clk);  // halt watched by the bound checks
        end
        $display("summary: %0d tests passed, %0d failed, %0d errors, %0d assertion failures",
                 test_pass, test_fail, err_count, u_dut.u_asserts.fail_count);
        if (!timed_out && (err_count == 0) && (test_fail == 0) &&
            (bytes_seen == NUM_BYTES) && (u_dut.u_asserts.fail_count == 0)) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
source/rv_pkg.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_exec.sv
source/rv_mem.sv
source/rv_core.sv
bench/rv_core_asserts.sv
bench/tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - files:
      - source/rv_pkg.sv
      - source/rv_decode.sv
      - source/rv_regfile.sv
      - source/rv_exec.sv
      - source/rv_mem.sv
      - source/rv_core.sv
  - target: test
    files:
      - bench/rv_core_asserts.sv
      - bench/tb_rv_core.sv

// ==== program.hex ====
// one 32-bit instruction word per line, word 0 at byte address 0
// trailing comment gives the byte address and the assembly
00020FB7 // 000 lui   x31,0x20
03100F13 // 004 addi  x30,x0,'1'
06400093 // 008 addi  x1,x0,100
FF900113 // 00c addi  x2,x0,-7
002081B3 // 010 add   x3,x1,x2
05D00213 // 014 addi  x4,x0,93
00418463 // 018 beq   x3,x4,+8
04600F13 // 01c addi  x30,x0,'F'
402081B3 // 020 sub   x3,x1,x2
06B00213 // 024 addi  x4,x0,107
00418463 // 028 beq   x3,x4,+8
04600F13 // 02c addi  x30,x0,'F'
0020F1B3 // 030 and   x3,x1,x2
06000213 // 034 addi  x4,x0,96
00418463 // 038 beq   x3,x4,+8
04600F13 // 03c addi  x30,x0,'F'
0020E1B3 // 040 or    x3,x1,x2
FFD00213 // 044 addi  x4,x0,-3
00418463 // 048 beq   x3,x4,+8
04600F13 // 04c addi  x30,x0,'F'
FFF0C193 // 050 xori  x3,x1,-1
F9B00213 // 054 addi  x4,x0,-101
00418463 // 058 beq   x3,x4,+8
04600F13 // 05c addi  x30,x0,'F'
00409193 // 060 slli  x3,x1,4
64000213 // 064 addi  x4,x0,1600
00418463 // 068 beq   x3,x4,+8
04600F13 // 06c addi  x30,x0,'F'
40115193 // 070 srai  x3,x2,1
FFC00213 // 074 addi  x4,x0,-4
00418463 // 078 beq   x3,x4,+8
04600F13 // 07c addi  x30,x0,'F'
01C15193 // 080 srli  x3,x2,28
00F00213 // 084 addi  x4,x0,15
00418463 // 088 beq   x3,x4,+8
04600F13 // 08c addi  x30,x0,'F'
001121B3 // 090 slt   x3,x2,x1
00100213 // 094 addi  x4,x0,1
00418463 // 098 beq   x3,x4,+8
04600F13 // 09c addi  x30,x0,'F'
001131B3 // 0a0 sltu  x3,x2,x1
00018463 // 0a4 beq   x3,x0,+8
04600F13 // 0a8 addi  x30,x0,'F'
0007F1B7 // 0ac lui   x3,0x7f
07F00213 // 0b0 addi  x4,x0,0x7f
00C21213 // 0b4 slli  x4,x4,12
00418463 // 0b8 beq   x3,x4,+8
04600F13 // 0bc addi  x30,x0,'F'
00000197 // 0c0 auipc x3,0
0C000213 // 0c4 addi  x4,x0,0xc0
00418463 // 0c8 beq   x3,x4,+8
04600F13 // 0cc addi  x30,x0,'F'
03EF8023 // 0d0 sb    x30,0x20(x31)
03200F13 // 0d4 addi  x30,x0,'2'
00108463 // 0d8 beq   x1,x1,+8
04600F13 // 0dc addi  x30,x0,'F'
00209463 // 0e0 bne   x1,x2,+8
04600F13 // 0e4 addi  x30,x0,'F'
00114463 // 0e8 blt   x2,x1,+8
04600F13 // 0ec addi  x30,x0,'F'
0020D463 // 0f0 bge   x1,x2,+8
04600F13 // 0f4 addi  x30,x0,'F'
0020E463 // 0f8 bltu  x1,x2,+8
04600F13 // 0fc addi  x30,x0,'F'
00117463 // 100 bgeu  x2,x1,+8
04600F13 // 104 addi  x30,x0,'F'
00208463 // 108 beq   x1,x2,+8
0080006F // 10c jal   x0,+8
04600F13 // 110 addi  x30,x0,'F'
00109463 // 114 bne   x1,x1,+8
0080006F // 118 jal   x0,+8
04600F13 // 11c addi  x30,x0,'F'
0020C463 // 120 blt   x1,x2,+8
0080006F // 124 jal   x0,+8
04600F13 // 128 addi  x30,x0,'F'
00115463 // 12c bge   x2,x1,+8
0080006F // 130 jal   x0,+8
04600F13 // 134 addi  x30,x0,'F'
00116463 // 138 bltu  x2,x1,+8
0080006F // 13c jal   x0,+8
04600F13 // 140 addi  x30,x0,'F'
0020F463 // 144 bgeu  x1,x2,+8
0080006F // 148 jal   x0,+8
04600F13 // 14c addi  x30,x0,'F'
008002EF // 150 jal   x5,+8
04600F13 // 154 addi  x30,x0,'F'
15400213 // 158 addi  x4,x0,0x154
00428463 // 15c beq   x5,x4,+8
04600F13 // 160 addi  x30,x0,'F'
16700393 // 164 addi  x7,x0,0x167
00A38367 // 168 jalr  x6,10(x7)
04600F13 // 16c addi  x30,x0,'F'
16C00213 // 170 addi  x4,x0,0x16c
00430463 // 174 beq   x6,x4,+8
04600F13 // 178 addi  x30,x0,'F'
03EF8023 // 17c sb    x30,0x20(x31)
03300F13 // 180 addi  x30,x0,'3'
00001437 // 184 lui   x8,0x1
112234B7 // 188 lui   x9,0x11223
34448493 // 18c addi  x9,x9,0x344
00942023 // 190 sw    x9,0(x8)
08500513 // 194 addi  x10,x0,0x85
00A400A3 // 198 sb    x10,1(x8)
FFE00593 // 19c addi  x11,x0,-2
00B41123 // 1a0 sh    x11,2(x8)
00042603 // 1a4 lw    x12,0(x8)
FFFE8237 // 1a8 lui   x4,0xfffe8
54420213 // 1ac addi  x4,x4,0x544
00460463 // 1b0 beq   x12,x4,+8
04600F13 // 1b4 addi  x30,x0,'F'
00140603 // 1b8 lb    x12,1(x8)
F8500213 // 1bc addi  x4,x0,-123
00460463 // 1c0 beq   x12,x4,+8
04600F13 // 1c4 addi  x30,x0,'F'
00144603 // 1c8 lbu   x12,1(x8)
08500213 // 1cc addi  x4,x0,0x85
00460463 // 1d0 beq   x12,x4,+8
04600F13 // 1d4 addi  x30,x0,'F'
00241603 // 1d8 lh    x12,2(x8)
00B60463 // 1dc beq   x12,x11,+8
04600F13 // 1e0 addi  x30,x0,'F'
00245603 // 1e4 lhu   x12,2(x8)
01059213 // 1e8 slli  x4,x11,16
01025213 // 1ec srli  x4,x4,16
00460463 // 1f0 beq   x12,x4,+8
04600F13 // 1f4 addi  x30,x0,'F'
00044603 // 1f8 lbu   x12,0(x8)
04400213 // 1fc addi  x4,x0,0x44
00460463 // 200 beq   x12,x4,+8
04600F13 // 204 addi  x30,x0,'F'
03EF8023 // 208 sb    x30,0x20(x31)
03400F13 // 20c addi  x30,x0,'4'
00008013 // 210 addi  x0,x1,0
40008633 // 214 sub   x12,x1,x0
00160463 // 218 beq   x12,x1,+8
04600F13 // 21c addi  x30,x0,'F'
03EF8023 // 220 sb    x30,0x20(x31)
03500F13 // 224 addi  x30,x0,'5'
03EF8023 // 228 sb    x30,0x20(x31)
04400F13 // 22c addi  x30,x0,'D'
03EF8023 // 230 sb    x30,0x20(x31)
0000006F // 234 jal   x0,0
